/* rtl/eth_fcs_pkg.sv */
// Ethernet FCS inserter shared types and constants

package eth_fcs_pkg;

    // byte lanes on the stream
    localparam int lanes  = 8;
    localparam int data_w = lanes * 8;

    // one stream beat
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [lanes-1:0]  keep;
        logic              last;
        logic              user;
    } axis_beat_t;

    // Ethernet CRC-32, normal form of the polynomial
    localparam logic [31:0] crc_poly = 32'h04c11db7;
    localparam logic [31:0] crc_init = 32'hffffffff;

    typedef logic [31:0] crc_t;

    // entry k is the CRC after bytes 0..k of the beat
    typedef crc_t crc_lane_t [lanes];

    // merged last beat and the spill beat behind it
    typedef struct packed {
        logic [data_w-1:0] beat0_data;
        logic [lanes-1:0]  beat0_keep;
        logic [data_w-1:0] beat1_data;
        logic [lanes-1:0]  beat1_keep;
    } tail_t;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_payload = 2'd1,
        st_fcs     = 2'd2
    } fcs_state_t;

endpackage

/* rtl/crc32_lanes.sv */
// Running CRC-32 with per-lane partial results

`timescale 1ns/100ps

module crc32_lanes (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          crc_clear,
    input  logic                          crc_update,
    input  logic [eth_fcs_pkg::data_w-1:0] data,
    output eth_fcs_pkg::crc_lane_t        crc_next
);
    import eth_fcs_pkg::*;

    // bit-reverse a 32-bit word
    function automatic crc_t reflect32(input crc_t v);
        crc_t r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31-i];
        end
        return r;
    endfunction

    // reflected form, 0xedb88320
    localparam crc_t poly_rev = reflect32(crc_poly);

    // one byte through the LSB-first shift register
    function automatic crc_t crc_byte(input crc_t crc, input logic [7:0] b);
        crc_t c;
        c = crc ^ {24'd0, b};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ poly_rev;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    crc_t crc_reg;

    // lane 0 starts from the stored value, each later lane from the one before
    always_comb begin
        crc_next[0] = crc_byte(crc_reg, data[7:0]);
        for (int k = 1; k < lanes; k++) begin
            crc_next[k] = crc_byte(crc_next[k-1], data[k*8 +: 8]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_reg <= crc_init;
        end else if (crc_clear) begin
            crc_reg <= crc_init;
        end else if (crc_update) begin
            crc_reg <= crc_next[lanes-1];
        end
    end

endmodule

/* rtl/fcs_tail_merge.sv */
// FCS placement into the last beat and the spill beat

`timescale 1ns/100ps

module fcs_tail_merge (
    input  logic [eth_fcs_pkg::data_w-1:0] data,
    input  logic [eth_fcs_pkg::lanes-1:0]  keep,
    input  eth_fcs_pkg::crc_lane_t         crc_next,
    output eth_fcs_pkg::tail_t             tail
);
    import eth_fcs_pkg::*;

    // length of the run of set keep bits from lane 0
    function automatic logic [3:0] keep_count(input logic [lanes-1:0] k);
        logic [3:0] n;
        n = 4'd0;
        for (int i = 0; i < lanes; i++) begin
            if (k[i] && n == 4'(i)) begin
                n = 4'(i + 1);
            end
        end
        return n;
    endfunction

    logic [3:0]          n;
    logic [2:0]          crc_sel;
    crc_t                fcs;
    logic [2*data_w-1:0] merged;
    logic [2*lanes-1:0]  merged_keep;

    always_comb begin
        n = keep_count(keep);
        crc_sel = 3'(n - 4'd1);
        fcs = ~crc_next[crc_sel];

        // masked data leaves the lanes above n at zero
        merged = {{data_w{1'b0}}, data} | ({{(2*data_w-32){1'b0}}, fcs} << (8 * n));
        merged_keep = 16'hffff >> (4'd12 - n);

        // empty last beat carries nothing
        if (n == 4'd0) begin
            merged = '0;
            merged_keep = '0;
        end

        tail.beat0_data = merged[data_w-1:0];
        tail.beat0_keep = merged_keep[lanes-1:0];
        tail.beat1_data = merged[2*data_w-1:data_w];
        tail.beat1_keep = merged_keep[2*lanes-1:lanes];
    end

endmodule

/* rtl/fcs_insert_ctrl.sv */
// FCS inserter frame control

`timescale 1ns/100ps

module fcs_insert_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_fcs_pkg::axis_beat_t in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    output eth_fcs_pkg::axis_beat_t int_beat,
    output logic                    int_valid,
    input  logic                    int_ready,
    input  logic                    ready_early,
    output logic                    busy
);
    import eth_fcs_pkg::*;

    fcs_state_t        state;
    fcs_state_t        state_next;
    logic              in_ready_next;
    logic              in_xfer;
    logic [data_w-1:0] mask_data;
    logic              crc_clear;
    logic              crc_update;
    crc_lane_t         crc_next;
    tail_t             tail;
    logic              spill_load;
    logic [data_w-1:0] spill_data;
    logic [lanes-1:0]  spill_keep;

    assign in_xfer = in_valid & in_ready;

    // zero the lanes keep does not select
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            mask_data[i*8 +: 8] = in_beat.keep[i] ? in_beat.data[i*8 +: 8] : 8'd0;
        end
    end

    crc32_lanes u_crc (
        .clk        (clk),
        .rst        (rst),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .data       (mask_data),
        .crc_next   (crc_next)
    );

    fcs_tail_merge u_tail (
        .data     (mask_data),
        .keep     (in_beat.keep),
        .crc_next (crc_next),
        .tail     (tail)
    );

    always_comb begin
        state_next = state;
        in_ready_next = 1'b0;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        spill_load = 1'b0;

        int_beat.data = mask_data;
        int_beat.keep = in_beat.keep;
        int_beat.last = 1'b0;
        int_beat.user = 1'b0;
        int_valid = 1'b0;

        case (state)
            st_idle, st_payload: begin
                in_ready_next = ready_early;
                int_valid = in_xfer;
                if (in_xfer) begin
                    crc_update = 1'b1;
                    state_next = st_payload;
                    if (in_beat.last) begin
                        crc_clear = 1'b1;
                        state_next = st_idle;
                        int_beat.last = 1'b1;
                        if (in_beat.user) begin
                            // bad frame goes out as is
                            int_beat.user = 1'b1;
                        end else begin
                            int_beat.data = tail.beat0_data;
                            int_beat.keep = tail.beat0_keep;
                            if (tail.beat1_keep != '0) begin
                                // FCS spills into one more beat
                                int_beat.last = 1'b0;
                                spill_load = 1'b1;
                                in_ready_next = 1'b0;
                                state_next = st_fcs;
                            end
                        end
                    end
                end
            end
            st_fcs: begin
                int_beat.data = spill_data;
                int_beat.keep = spill_keep;
                int_beat.last = 1'b1;
                int_valid = int_ready;
                if (int_ready) begin
                    in_ready_next = ready_early;
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            in_ready <= 1'b0;
            busy <= 1'b0;
        end else begin
            state <= state_next;
            in_ready <= in_ready_next;
            busy <= (state_next != st_idle);
        end
    end

    always_ff @(posedge clk) begin
        if (spill_load) begin
            spill_data <= tail.beat1_data;
            spill_keep <= tail.beat1_keep;
        end
    end

endmodule

/* rtl/axis_skid_buffer.sv */
// Registered output stage with one-beat skid

`timescale 1ns/100ps

module axis_skid_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_fcs_pkg::axis_beat_t int_beat,
    input  logic                    int_valid,
    output logic                    int_ready,
    output logic                    ready_early,
    output eth_fcs_pkg::axis_beat_t out_beat,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import eth_fcs_pkg::*;

    axis_beat_t temp_beat;
    logic       temp_valid;
    logic       out_valid_next;
    logic       temp_valid_next;
    logic       int_to_out;
    logic       int_to_temp;
    logic       temp_to_out;

    // temp stays empty next cycle unless the output is full and a beat comes in
    assign ready_early = out_ready | (~temp_valid & (~out_valid | ~int_valid));

    always_comb begin
        out_valid_next = out_valid;
        temp_valid_next = temp_valid;
        int_to_out = 1'b0;
        int_to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (int_ready) begin
            if (out_ready | ~out_valid) begin
                out_valid_next = int_valid;
                int_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next = int_valid;
                int_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // drain temp first to keep order
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
            int_ready <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
            int_ready <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            out_beat <= int_beat;
        end else if (temp_to_out) begin
            out_beat <= temp_beat;
        end

        if (int_to_temp) begin
            temp_beat <= int_beat;
        end
    end

endmodule

/* rtl/eth_fcs_insert.sv */
// Ethernet FCS inserter, 64-bit stream

`timescale 1ns/100ps

module eth_fcs_insert (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_fcs_pkg::axis_beat_t in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    output eth_fcs_pkg::axis_beat_t out_beat,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    busy
);

    eth_fcs_pkg::axis_beat_t int_beat;
    logic                    int_valid;
    logic                    int_ready;
    logic                    ready_early;

    fcs_insert_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .int_beat    (int_beat),
        .int_valid   (int_valid),
        .int_ready   (int_ready),
        .ready_early (ready_early),
        .busy        (busy)
    );

    axis_skid_buffer u_skid (
        .clk         (clk),
        .rst         (rst),
        .int_beat    (int_beat),
        .int_valid   (int_valid),
        .int_ready   (int_ready),
        .ready_early (ready_early),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

/* tests/tb_eth_fcs_insert.sv */
// Testbench for the Ethernet FCS inserter

`timescale 1ns/100ps

module tb_eth_fcs_insert;
    import eth_fcs_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    localparam int num_frames = 200;
    localparam int max_cycles = 4 * num_frames * 8 + 200;

    logic       clk;
    logic       rst;
    axis_beat_t in_beat;
    logic       in_valid;
    logic       in_ready;
    axis_beat_t out_beat;
    logic       out_valid;
    logic       out_ready;
    logic       busy;

    logic [31:0] stim_rng = 32'h434a1a2f;
    logic [31:0] stall_rng = 32'h434a1a2f ^ 32'h9e3779b9;

    int value_errors = 0;
    int other_errors = 0;
    int checks_run = 0;
    int frames_checked = 0;

    // expected frames as a flat byte stream plus per-frame info
    byte_q_t    exp_bytes;
    int         exp_len_q [$];
    bit         exp_err_q [$];
    // received frames from the monitor
    byte_q_t    rx_bytes;
    int         rx_len_q [$];
    int         rx_beats_q [$];
    logic [7:0] rx_keep_q [$];
    bit         rx_user_q [$];
    int         rx_frame_bytes = 0;
    int         rx_frame_beats = 0;
    int         rx_frames_seen = 0;

    eth_fcs_insert UUT (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reflected CRC-32 with 04C11DB7 bit-reversed to EDB88320
    function automatic logic [31:0] crc32_ref(input byte_q_t bytes);
        logic [31:0] c;
        c = 32'hffffffff;
        foreach (bytes[i]) begin
            c = c ^ {24'd0, bytes[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    function automatic byte_q_t expected_frame(input byte_q_t payload, input bit err);
        byte_q_t     q;
        logic [31:0] fcs;
        q = payload;
        if (!err) begin
            fcs = crc32_ref(payload);
            for (int i = 0; i < 4; i++) begin
                q.push_back(fcs[i*8 +: 8]);
            end
        end
        return q;
    endfunction

    task automatic compare_value(input string name, input int frame,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checks_run++;
        assert (actual === expected) else begin
            value_errors++;
            $display("ERR %s frame %0d: expected %0h, actual %0h", name, frame, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks_run, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // no output and no busy until the first beat goes in
    task automatic check_after_reset();
        int waited;
        waited = 0;
        while (!in_ready && waited < 2) begin
            @(posedge clk);
            waited++;
            assert (!out_valid && !busy) else begin
                other_errors++;
                $display("out_valid or busy went high after reset with no input");
            end
        end
        assert (in_ready) else begin
            other_errors++;
            $display("in_ready did not rise within two cycles of reset release");
        end
    endtask

    task automatic send_frame(input byte_q_t payload, input bit err);
        axis_beat_t beat;
        int         pos;
        int         n;
        pos = 0;
        while (pos < payload.size()) begin
            stim_rng = xorshift32(stim_rng);
            if (stim_rng[1:0] == 2'b00) begin
                in_valid <= 1'b0;
                repeat (1 + stim_rng[3:2]) @(posedge clk);
            end
            n = payload.size() - pos;
            if (n > lanes) begin
                n = lanes;
            end
            // unused lanes carry random bytes
            stim_rng = xorshift32(stim_rng);
            beat.data[31:0] = stim_rng;
            stim_rng = xorshift32(stim_rng);
            beat.data[63:32] = stim_rng;
            for (int i = 0; i < n; i++) begin
                beat.data[i*8 +: 8] = payload[pos + i];
            end
            beat.keep = 8'((16'd1 << n) - 16'd1);
            beat.last = (pos + n == payload.size());
            beat.user = beat.last && err;
            in_beat <= beat;
            in_valid <= 1'b1;
            @(posedge clk);
            while (!in_ready) @(posedge clk);
            pos += n;
        end
    endtask

    initial begin : stall_drive
        out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            stall_rng = xorshift32(stall_rng);
            out_ready <= (stall_rng[1:0] != 2'b00);
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            rx_frame_beats++;
            for (int i = 0; i < lanes; i++) begin
                if (out_beat.keep[i]) begin
                    rx_bytes.push_back(out_beat.data[i*8 +: 8]);
                    rx_frame_bytes++;
                end else begin
                    compare_value("idle_lane_zero", rx_frames_seen, 32'h0,
                                  out_beat.data[i*8 +: 8]);
                end
            end
            if (out_beat.last) begin
                rx_len_q.push_back(rx_frame_bytes);
                rx_beats_q.push_back(rx_frame_beats);
                rx_keep_q.push_back(out_beat.keep);
                rx_user_q.push_back(out_beat.user);
                rx_frames_seen++;
                rx_frame_bytes = 0;
                rx_frame_beats = 0;
            end else begin
                compare_value("mid_keep", rx_frames_seen, 32'hff, out_beat.keep);
                compare_value("mid_user", rx_frames_seen, 32'h0, out_beat.user);
            end
        end
    end

    initial begin : compare_frames
        byte_q_t    exp_q;
        byte_q_t    got_q;
        int         exp_len;
        int         got_len;
        int         rem;
        logic [7:0] exp_keep;
        bit         exp_err;
        for (int f = 0; f < num_frames; f++) begin
            while (rx_len_q.size() == 0) @(negedge clk);
            exp_len = exp_len_q.pop_front();
            exp_err = exp_err_q.pop_front();
            got_len = rx_len_q.pop_front();
            exp_q.delete();
            got_q.delete();
            repeat (exp_len) exp_q.push_back(exp_bytes.pop_front());
            repeat (got_len) got_q.push_back(rx_bytes.pop_front());
            compare_value("frame_length", f, exp_len, got_len);
            for (int i = 0; i < exp_len && i < got_len; i++) begin
                compare_value("frame_byte", f, exp_q[i], got_q[i]);
            end
            rem = exp_len % 8;
            exp_keep = (rem == 0) ? 8'hff : 8'((16'd1 << rem) - 16'd1);
            compare_value("beat_count", f, (exp_len + 7) / 8, rx_beats_q.pop_front());
            compare_value("last_keep", f, exp_keep, rx_keep_q.pop_front());
            compare_value("last_user", f, exp_err, rx_user_q.pop_front());
            frames_checked++;
        end
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        other_errors++;
        $display("timeout, run did not finish within %0d cycles", max_cycles);
        finish_run();
    end

    initial begin : stimulus
        byte_q_t payload;
        byte_q_t expect_q;
        int      len;
        bit      err;
        rst <= 1'b1;
        in_valid <= 1'b0;
        in_beat <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        check_after_reset();
        for (int f = 0; f < num_frames; f++) begin
            // first frames sweep every length from 1 to 16
            stim_rng = xorshift32(stim_rng);
            len = (f < 16) ? f + 1 : 1 + int'(stim_rng % 32'd40);
            stim_rng = xorshift32(stim_rng);
            err = (f >= 16) && (stim_rng[10:8] == 3'd0);
            payload.delete();
            for (int i = 0; i < len; i++) begin
                stim_rng = xorshift32(stim_rng);
                payload.push_back(stim_rng[7:0]);
            end
            expect_q = expected_frame(payload, err);
            foreach (expect_q[i]) exp_bytes.push_back(expect_q[i]);
            exp_len_q.push_back(expect_q.size());
            exp_err_q.push_back(err);
            send_frame(payload, err);
        end
        in_valid <= 1'b0;
        while (frames_checked < num_frames) @(negedge clk);
        repeat (10) @(negedge clk);
        assert (rx_len_q.size() == 0 && rx_bytes.size() == 0) else begin
            other_errors++;
            $display("extra output beats arrived after the last frame");
        end
        assert (!busy) else begin
            other_errors++;
            $display("busy still high after the last frame left");
        end
        finish_run();
    end

endmodule

/* src.f */
rtl/eth_fcs_pkg.sv
rtl/crc32_lanes.sv
rtl/fcs_tail_merge.sv
rtl/fcs_insert_ctrl.sv
rtl/axis_skid_buffer.sv
rtl/eth_fcs_insert.sv
tests/tb_eth_fcs_insert.sv
